// ==== scoreboard_top.f ====
source/scoreboard_pkg.sv
source/digit_set_if.sv
source/countdown_timer.sv
source/timer_display.sv
source/refresh_strobe.sv
source/frame_scanner.sv
source/digit_glyph.sv
source/frame_compositor.sv
source/scoreboard_top.sv
dv/scoreboard_tb.sv

// ==== Makefile ====
# Verilator build and run for the scoreboard testbench

VERILATOR ?= verilator
TOP ?= scoreboard_tb
FILELIST ?= scoreboard_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_MSG ?= ALL CHECKS PASSED

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/scoreboard_cases.txt ====
# R: restart | S tens ones: score digits | P x y colour: pixel with expected colour
# T x y: timer digit pixel, colour from the timer model | colour 7 is white, 0 black
S 4 7
P 5 5 0
P 20 53 0
P 11 60 7
P 15 60 0
P 32 60 7
P 20 74 7
P 11 80 0
P 50 53 7
P 40 60 0
P 60 84 7
P 50 94 0
T 110 53
T 110 74
T 140 94
R
S 9 0
P 20 94 0
P 20 74 7
P 30 84 7
P 50 74 0
P 60 80 7
T 100 60
T 130 74
P 80 20 0
P 159 119 0

// ==== dv/scoreboard_tb.sv ====
module scoreboard_tb;

	localparam int TICK_CYCLES = 20;
	localparam int START_TIME = 12;
	localparam int REFRESH_CYCLES = 20000;
	localparam int FRAME_PIXELS = 160 * 120;

	logic iClock;
	logic resetn;
	logic timer_restartn;
	logic [3:0] score_tens;
	logic [3:0] score_ones;
	logic timer_done;
	logic [6:0] hex_tens;
	logic [6:0] hex_ones;
	logic [7:0] pixel_x;
	logic [6:0] pixel_y;
	logic [2:0] pixel_colour;
	logic plot;

	byte case_kind [$];	// R, S, P or T
	int case_a [$];
	int case_b [$];
	int case_c [$];
	int model_secs;	// countdown model
	int errors = 0;	// main flow errors
	int scan_errors = 0;	// raster monitor errors
	int tests_run = 0;
	int tests_failed = 0;
	int test_mark = 0;	// errors at start of current test
	int periods_done = 0;	// full refresh periods seen
	bit scan_on = 1'b0;
	bit cases_loaded = 1'b0;
	int exp_x = 0;	// raster model
	int exp_y = 0;
	int run_len = 0;	// cycles at current plot level
	bit plot_prev = 1'b1;

	scoreboard_top #(
		.TICK_CYCLES    (TICK_CYCLES),
		.START_TIME     (START_TIME),
		.REFRESH_CYCLES (REFRESH_CYCLES)
	) i_dut (
		.iClock         (iClock),
		.resetn         (resetn),
		.timer_restartn (timer_restartn),
		.score_tens     (score_tens),
		.score_ones     (score_ones),
		.timer_done     (timer_done),
		.hex_tens       (hex_tens),
		.hex_ones       (hex_ones),
		.pixel_x        (pixel_x),
		.pixel_y        (pixel_y),
		.pixel_colour   (pixel_colour),
		.plot           (plot)
	);

	always #5 iClock = ~iClock;

	// lit segments with bit 0 as a up to bit 6 as g
	function automatic logic [6:0] segments_on(input int d);
		case (d)
			0: return 7'b0111111;
			1: return 7'b0000110;
			2: return 7'b1011011;
			3: return 7'b1001111;
			4: return 7'b1100110;
			5: return 7'b1101101;
			6: return 7'b1111101;
			7: return 7'b0000111;
			8: return 7'b1111111;
			9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic int tens_of(input int s);
		return (s >= 60) ? 0 : s / 10;	// 60 and up shows 00
	endfunction

	function automatic int ones_of(input int s);
		return (s >= 60) ? 0 : s % 10;
	endfunction

	// 11 bands of 4 lines
	// bar in columns 4..19 and strokes at 0..3 and 20..23
	function automatic bit glyph_lit(input int d, input int lx, input int ly);
		logic [6:0] on;
		bit bar;
		bit is_left;
		bit is_right;
		int band;
		on = segments_on(d);
		if (d == 9)
			on[3] = 1'b0;	// glyph 9 has an open bottom
		bar = (lx >= 4) && (lx < 20);
		is_left = (lx >= 0) && (lx < 4);
		is_right = (lx >= 20) && (lx < 24);
		band = ly / 4;
		if (ly < 0 || ly >= 44)
			return 1'b0;	// outside the box
		if (band == 0)
			return bar && on[0];
		if (band <= 4)
			return (is_left && on[5]) || (is_right && on[1]);
		if (band == 5)
			return bar && on[6];
		if (band <= 9)
			return (is_left && on[4]) || (is_right && on[2]);
		return bar && on[3];
	endfunction

	task automatic print_mismatch(input string sig, input int expv, input int actv);
		$display("FAIL t=%0t %s expected %0d got %0d", $time, sig, expv, actv);
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_mark)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_mark);
		end
		test_mark = errors;
	endtask

	// one case per line with the kind letter first
	task automatic load_cases();
		int fd;
		int n;
		int a;
		int b;
		int c;
		string line;
		fd = $fopen("dv/scoreboard_cases.txt", "r");
		if (fd == 0)
		begin
			report_problem("cannot open dv/scoreboard_cases.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#")	// skip blanks and comments
			begin
				a = 0;
				b = 0;
				c = 0;
				n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c);
				case_kind.push_back(line[0]);
				case_a.push_back(a);
				case_b.push_back(b);
				case_c.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// hex outputs and done flag against the countdown model
	task automatic check_display();
		logic [6:0] exp_tens;
		logic [6:0] exp_ones;
		exp_tens = ~segments_on(tens_of(model_secs));	// active low
		exp_ones = ~segments_on(ones_of(model_secs));
		if (hex_tens !== exp_tens)
		begin
			print_mismatch("hex_tens", int'(exp_tens), int'(hex_tens));
			errors++;
		end
		if (hex_ones !== exp_ones)
		begin
			print_mismatch("hex_ones", int'(exp_ones), int'(hex_ones));
			errors++;
		end
		if (timer_done !== (model_secs == 0))
		begin
			print_mismatch("timer_done", int'(model_secs == 0), int'(timer_done));
			errors++;
		end
	endtask

	// each display change is one second lower until the hold at 00
	task automatic run_countdown();
		logic [13:0] prev;
		int waited;
		bit stuck;
		stuck = 1'b0;
		for (int step = 0; step < START_TIME && !stuck; step++)
		begin
			prev = {hex_tens, hex_ones};
			waited = 0;
			while ({hex_tens, hex_ones} == prev && waited <= TICK_CYCLES + 1)
			begin
				@(negedge iClock);
				waited++;
			end
			if ({hex_tens, hex_ones} == prev)
			begin
				report_problem("timer display did not change within one tick period");
				stuck = 1'b1;
			end
			else
			begin
				model_secs--;
				check_display();
			end
		end
		prev = {hex_tens, hex_ones};
		for (int w = 0; w < 3 * TICK_CYCLES && !stuck; w++)
		begin
			@(negedge iClock);
			if ({hex_tens, hex_ones} !== prev || timer_done !== 1'b1)
			begin
				report_problem("display or done flag moved after the count reached zero");
				stuck = 1'b1;
			end
		end
	endtask

	task automatic do_restart();
		@(posedge iClock);
		timer_restartn <= 1'b0;	// one cycle low
		@(posedge iClock);
		timer_restartn <= 1'b1;
		@(negedge iClock);
		model_secs = START_TIME;
		check_display();
		end_test("restart");
		run_countdown();
		end_test("countdown after restart");
	endtask

	// wait for the scan to reach (x, y) and compare its colour
	task automatic check_pixel(input int x, input int y, input int expc);
		int waited;
		waited = 0;
		@(negedge iClock);
		while (!(plot && int'(pixel_x) == x && int'(pixel_y) == y) && waited <= REFRESH_CYCLES)
		begin
			@(negedge iClock);
			waited++;
		end
		if (waited > REFRESH_CYCLES)
			report_problem($sformatf("pixel %0d,%0d was never scanned", x, y));
		else if (int'(pixel_colour) != expc)
		begin
			print_mismatch("pixel_colour", expc, int'(pixel_colour));
			errors++;
		end
	endtask

	// raster order and plot window lengths on every cycle after reset
	always @(negedge iClock)
	begin
		if (scan_on)
		begin
			if (plot !== plot_prev)
			begin
				if (plot_prev && run_len != FRAME_PIXELS)
				begin
					print_mismatch("plot high cycles", FRAME_PIXELS, run_len);
					scan_errors++;
				end
				if (!plot_prev && run_len != REFRESH_CYCLES - FRAME_PIXELS)
				begin
					print_mismatch("plot low cycles", REFRESH_CYCLES - FRAME_PIXELS, run_len);
					scan_errors++;
				end
				if (!plot_prev)
					periods_done++;	// low run ended so the period is complete
				run_len = 0;
			end
			run_len++;
			plot_prev = plot;
			if (plot)
			begin
				if (int'(pixel_x) != exp_x || int'(pixel_y) != exp_y)
				begin
					print_mismatch("pixel_x", exp_x, int'(pixel_x));
					print_mismatch("pixel_y", exp_y, int'(pixel_y));
					scan_errors++;
					exp_x = int'(pixel_x);	// resync after a slip
					exp_y = int'(pixel_y);
				end
				exp_x++;
				if (exp_x == 160)
				begin
					exp_x = 0;
					exp_y = (exp_y + 1) % 120;
				end
			end
		end
	end

	initial
	begin
		longint limit;
		wait (cases_loaded);
		limit = longint'(case_kind.size() + 3) * REFRESH_CYCLES * 10;	// one period per case
		#(limit);
		$display("watchdog: run did not finish within %0d time units", limit);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		bit lit;
		iClock = 1'b0;
		resetn <= 1'b0;
		timer_restartn <= 1'b1;
		score_tens <= 4'd0;
		score_ones <= 4'd0;
		load_cases();
		cases_loaded = 1'b1;
		repeat (5) @(posedge iClock);
		resetn <= 1'b1;
		scan_on = 1'b1;	// monitor starts at the next falling edge
		@(negedge iClock);
		model_secs = START_TIME;
		check_display();
		if (plot !== 1'b1 || pixel_x !== 8'd0 || pixel_y !== 7'd0)
			report_problem("no plotted pixel at (0,0) right after reset");
		end_test("after reset");
		run_countdown();
		end_test("countdown");
		for (int i = 0; i < case_kind.size(); i++)
		begin
			case (case_kind[i])
				"R": do_restart();
				"S":
				begin
					@(posedge iClock);
					score_tens <= 4'(case_a[i]);
					score_ones <= 4'(case_b[i]);
				end
				"P":
				begin
					check_pixel(case_a[i], case_b[i], case_c[i]);
					end_test($sformatf("pixel %0d,%0d", case_a[i], case_b[i]));
				end
				"T":
				begin
					if (case_a[i] >= 126)	// timer ones box
						lit = glyph_lit(ones_of(model_secs), case_a[i] - 126, case_b[i] - 52);
					else
						lit = glyph_lit(tens_of(model_secs), case_a[i] - 98, case_b[i] - 52);
					check_pixel(case_a[i], case_b[i], lit ? 7 : 0);
					end_test($sformatf("timer pixel %0d,%0d", case_a[i], case_b[i]));
				end
				default: report_problem($sformatf("unknown case kind in line %0d", i));
			endcase
		end
		for (int w = 0; w < 2 * REFRESH_CYCLES && periods_done == 0; w++)
			@(negedge iClock);
		tests_run++;
		if (scan_errors == 0 && periods_done > 0)
			$display("test refresh and scan: ok, %0d periods", periods_done);
		else
		begin
			tests_failed++;
			$display("test refresh and scan: %0d errors, %0d periods", scan_errors, periods_done);
		end
		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
			errors + scan_errors);
		if (errors == 0 && scan_errors == 0 && tests_failed == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== source/scoreboard_top.sv ====
module scoreboard_top #(
	parameter int unsigned TICK_CYCLES = 50_000_000,	// one second at 50 MHz
	parameter int unsigned START_TIME = 30,	// countdown start, below 60
	parameter int unsigned REFRESH_CYCLES = 2_500_000	// 20 refreshes per second
) (
	input logic iClock,
	input logic resetn,
	input logic timer_restartn,	// low reloads the timer
	input logic [3:0] score_tens,
	input logic [3:0] score_ones,
	output logic timer_done,
	output logic [6:0] hex_tens,	// active low segments
	output logic [6:0] hex_ones,
	output logic [7:0] pixel_x,
	output logic [6:0] pixel_y,
	output logic [2:0] pixel_colour,
	output logic plot	// pixel stream valid
);

	logic [9:0] seconds_left;	// timer to display

	digit_set_if digits ();	// four on-screen digits

	assign digits.score_tens = score_tens;	// score comes straight from the pins
	assign digits.score_ones = score_ones;

	countdown_timer #(
		.TICK_CYCLES (TICK_CYCLES),
		.START_TIME  (START_TIME)
	) i_timer (
		.iClock         (iClock),
		.resetn         (resetn),
		.timer_restartn (timer_restartn),
		.seconds_left   (seconds_left),
		.timer_done     (timer_done)
	);

	timer_display i_display (
		.seconds_left (seconds_left),
		.digits       (digits.source),
		.hex_tens     (hex_tens),
		.hex_ones     (hex_ones)
	);

	refresh_strobe #(
		.REFRESH_CYCLES (REFRESH_CYCLES)
	) i_refresh (
		.iClock (iClock),
		.resetn (resetn),
		.plot   (plot)
	);

	frame_scanner i_scanner (
		.iClock  (iClock),
		.resetn  (resetn),
		.plot    (plot),
		.pixel_x (pixel_x),
		.pixel_y (pixel_y)
	);

	frame_compositor i_compositor (
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.digits       (digits.sink),
		.pixel_colour (pixel_colour)
	);

endmodule

// ==== source/frame_compositor.sv ====
module frame_compositor (
	input scoreboard_pkg::pixel_x_t pixel_x,
	input scoreboard_pkg::pixel_y_t pixel_y,
	digit_set_if.sink digits,
	output scoreboard_pkg::colour_t pixel_colour	// same cycle as the coordinate
);
	import scoreboard_pkg::*;

	// left edges: score tens, score ones, timer tens, timer ones
	localparam pixel_x_t ORIGIN_X [4] = '{pixel_x_t'(DIGIT_X0), pixel_x_t'(DIGIT_X1),
		pixel_x_t'(DIGIT_X2), pixel_x_t'(DIGIT_X3)};

	bcd_digit_t digit_val [4];	// value shown in each box
	pixel_x_t local_x [4];	// pixel relative to each box
	pixel_y_t local_y;	// shared, all boxes on one line
	logic in_rows;	// inside the vertical span of the boxes
	logic [3:0] in_box;
	logic [3:0] lit;

	assign digit_val[0] = digits.score_tens;
	assign digit_val[1] = digits.score_ones;
	assign digit_val[2] = digits.timer_tens;
	assign digit_val[3] = digits.timer_ones;

	assign local_y = pixel_y - pixel_y_t'(DIGIT_Y);
	assign in_rows = (pixel_y >= pixel_y_t'(DIGIT_Y)) && (pixel_y < pixel_y_t'(DIGIT_Y + DIGIT_H));

	for (genvar i = 0; i < 4; i++)
	begin : g_digit
		assign local_x[i] = pixel_x - ORIGIN_X[i];
		assign in_box[i] = in_rows && (pixel_x >= ORIGIN_X[i])
			&& (pixel_x < ORIGIN_X[i] + pixel_x_t'(DIGIT_W));

		digit_glyph i_glyph (
			.digit   (digit_val[i]),
			.local_x (local_x[i]),
			.local_y (local_y),
			.lit     (lit[i])
		);
	end

	// boxes never overlap, so any lit hit means white
	assign pixel_colour = |(in_box & lit) ? COLOUR_WHITE : COLOUR_BLACK;

endmodule

// ==== source/digit_glyph.sv ====
module digit_glyph (
	input scoreboard_pkg::bcd_digit_t digit,
	input scoreboard_pkg::pixel_x_t local_x,	// 0 to DIGIT_W-1 inside the box
	input scoreboard_pkg::pixel_y_t local_y,	// 0 to DIGIT_H-1 inside the box
	output logic lit
);
	import scoreboard_pkg::*;

	// column 0 on the left, so index 0 is the msb of the literal
	localparam logic [0:DIGIT_W-1] ROW_BAR = 24'b0000_1111111111111111_0000;
	localparam logic [0:DIGIT_W-1] ROW_LEFT = 24'b1111_0000000000000000_0000;
	localparam logic [0:DIGIT_W-1] ROW_RIGHT = 24'b0000_0000000000000000_1111;

	logic [6:0] seg_on;	// active high, bit order g..a
	logic [4:0] band;	// bitmap row 0 to 10
	logic [0:DIGIT_W-1] row;	// pixels of the selected bitmap row

	// which bars and strokes a digit uses
	always_comb
	begin
		case (digit)
			4'd0: seg_on = 7'b0111111;
			4'd1: seg_on = 7'b0000110;
			4'd2: seg_on = 7'b1011011;
			4'd3: seg_on = 7'b1001111;
			4'd4: seg_on = 7'b1100110;
			4'd5: seg_on = 7'b1101101;
			4'd6: seg_on = 7'b1111101;
			4'd7: seg_on = 7'b0000111;
			4'd8: seg_on = 7'b1111111;
			4'd9: seg_on = 7'b1100111;	// open bottom, no bar d
			default: seg_on = 7'b0000000;
		endcase
	end

	assign band = 5'(local_y / pixel_y_t'(GLYPH_ROW_H));

	// 11 rows: top bar, 4 upper strokes, middle bar, 4 lower strokes, bottom bar
	always_comb
	begin
		row = '0;
		case (band)
			5'd0: row = seg_on[0] ? ROW_BAR : '0;	// a
			5'd1, 5'd2, 5'd3, 5'd4:
				row = (seg_on[5] ? ROW_LEFT : '0) | (seg_on[1] ? ROW_RIGHT : '0);	// f, b
			5'd5: row = seg_on[6] ? ROW_BAR : '0;	// g
			5'd6, 5'd7, 5'd8, 5'd9:
				row = (seg_on[4] ? ROW_LEFT : '0) | (seg_on[2] ? ROW_RIGHT : '0);	// e, c
			5'd10: row = seg_on[3] ? ROW_BAR : '0;	// d
			default: row = '0;	// below the glyph
		endcase
	end

	// guard keeps the bit select inside the row
	assign lit = (local_x < pixel_x_t'(DIGIT_W)) && row[local_x[4:0]];

endmodule

// ==== source/frame_scanner.sv ====
module frame_scanner (
	input logic iClock,
	input logic resetn,
	input logic plot,	// advance enable
	output scoreboard_pkg::pixel_x_t pixel_x,
	output scoreboard_pkg::pixel_y_t pixel_y
);
	import scoreboard_pkg::*;

	logic x_last;	// rightmost column
	logic y_last;	// bottom line

	assign x_last = (pixel_x == pixel_x_t'(SCREEN_W - 1));
	assign y_last = (pixel_y == pixel_y_t'(SCREEN_H - 1));

	// raster order, x fastest
	always_ff @(posedge iClock)
	begin
		if (!resetn)
		begin
			pixel_x <= '0;
			pixel_y <= '0;
		end
		else if (plot)
		begin
			if (x_last)
			begin
				pixel_x <= '0;
				if (y_last)
					pixel_y <= '0;	// frame done, back to top left
				else
					pixel_y <= pixel_y + 1'b1;
			end
			else
				pixel_x <= pixel_x + 1'b1;
		end
	end

endmodule

// ==== source/refresh_strobe.sv ====
module refresh_strobe #(
	parameter int unsigned REFRESH_CYCLES = 2_500_000	// clocks per refresh, >= FRAME_PIXELS
) (
	input logic iClock,
	input logic resetn,
	output logic plot	// high for one frame of pixels per period
);
	import scoreboard_pkg::*;

	localparam int unsigned CNT_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(REFRESH_CYCLES - 1);

	logic [CNT_W-1:0] period_cnt;	// position in the refresh period

	always_ff @(posedge iClock)
	begin
		if (!resetn)
			period_cnt <= '0;
		else if (period_cnt == CNT_LAST)
			period_cnt <= '0;	// next period
		else
			period_cnt <= period_cnt + 1'b1;
	end

	assign plot = (period_cnt < CNT_W'(FRAME_PIXELS));	// first FRAME_PIXELS cycles

endmodule

// ==== source/timer_display.sv ====
module timer_display (
	input scoreboard_pkg::seconds_t seconds_left,
	digit_set_if.source digits,	// only the timer fields are driven here
	output scoreboard_pkg::segments_t hex_tens,
	output scoreboard_pkg::segments_t hex_ones
);
	import scoreboard_pkg::*;

	bcd_digit_t tens;
	bcd_digit_t ones;

	// active low pattern in bit order g..a
	function automatic segments_t to_segments(input bcd_digit_t d);
		case (d)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;	// blank and never shown
		endcase
	endfunction

	// decade compare where 60 and up stays 00
	always_comb
	begin
		tens = '0;
		ones = '0;
		for (int d = 0; d < 6; d++)
		begin
			if (seconds_left >= seconds_t'(10 * d)
				&& seconds_left < seconds_t'(10 * d + 10))
			begin
				tens = bcd_digit_t'(d);
				ones = bcd_digit_t'(seconds_left - seconds_t'(10 * d));	// remainder < 10
			end
		end
	end

	assign digits.timer_tens = tens;	// to the on-screen timer
	assign digits.timer_ones = ones;
	assign hex_tens = to_segments(tens);
	assign hex_ones = to_segments(ones);

endmodule

// ==== source/countdown_timer.sv ====
module countdown_timer #(
	parameter int unsigned TICK_CYCLES = 50_000_000,	// clocks per one second tick
	parameter int unsigned START_TIME = 30	// reload value, below 60
) (
	input logic iClock,
	input logic resetn,
	input logic timer_restartn,	// held low keeps the count at START_TIME
	output scoreboard_pkg::seconds_t seconds_left,
	output logic timer_done	// high while count is zero
);
	import scoreboard_pkg::*;

	localparam int unsigned DIV_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [DIV_W-1:0] DIV_RELOAD = DIV_W'(TICK_CYCLES - 1);

	logic [DIV_W-1:0] div_cnt;	// tick divider, counts down
	logic tick;	// one cycle pulse per second

	assign tick = (div_cnt == '0) && !timer_done;	// frozen once done
	assign timer_done = (seconds_left == '0);

	// divider only restarts on reset or when the count has run out
	always_ff @(posedge iClock)
	begin
		if (!resetn || timer_done)
			div_cnt <= DIV_RELOAD;
		else if (div_cnt == '0)
			div_cnt <= DIV_RELOAD;	// wrap after the tick
		else
			div_cnt <= div_cnt - 1'b1;
	end

	// seconds register
	always_ff @(posedge iClock)
	begin
		if (!resetn || !timer_restartn)
			seconds_left <= seconds_t'(START_TIME);	// restart level wins over tick
		else if (tick)
			seconds_left <= seconds_left - 1'b1;
	end

endmodule

// ==== source/digit_set_if.sv ====
interface digit_set_if;
	import scoreboard_pkg::*;

	bcd_digit_t score_tens;	// left pair on screen
	bcd_digit_t score_ones;
	bcd_digit_t timer_tens;	// right pair on screen
	bcd_digit_t timer_ones;

	// producers of the digit values
	modport source (
		output score_tens, score_ones, timer_tens, timer_ones
	);

	// the frame compositor reads all four
	modport sink (
		input score_tens, score_ones, timer_tens, timer_ones
	);

endinterface

// ==== source/scoreboard_pkg.sv ====
package scoreboard_pkg;

	typedef logic [7:0] pixel_x_t;	// 0 to 159
	typedef logic [6:0] pixel_y_t;	// 0 to 119
	typedef logic [2:0] colour_t;	// {r, g, b}
	typedef logic [3:0] bcd_digit_t;	// one decimal digit
	typedef logic [9:0] seconds_t;	// remaining seconds
	typedef logic [6:0] segments_t;	// active low, bit 0 = seg a, bit 6 = seg g

	// display geometry
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int FRAME_PIXELS = SCREEN_W * SCREEN_H;	// 19200 pixels per frame

	// large digit glyph
	localparam int DIGIT_W = 24;
	localparam int DIGIT_H = 44;
	localparam int GLYPH_ROW_H = 4;	// screen lines per bitmap row

	// digit placement, all four share one top edge
	localparam int DIGIT_Y = 52;
	localparam int DIGIT_X0 = 10;	// score tens
	localparam int DIGIT_X1 = 38;	// score ones
	localparam int DIGIT_X2 = 98;	// timer tens
	localparam int DIGIT_X3 = 126;	// timer ones

	localparam colour_t COLOUR_BLACK = 3'b000;
	localparam colour_t COLOUR_WHITE = 3'b111;

endpackage
